// ==== design/lcd_pkg.sv ====
`default_nettype none

package lcd_pkg;

    // ------------------------------------------------------------
    // Clock and HD44780 timing in clk cycles
    // ------------------------------------------------------------
    localparam logic [31:0] clk_freq_hz = 32'd50_000_000;

    // 500 ns minimum enable phase plus one cycle of margin
    localparam int unsigned en_pulse_cyc = clk_freq_hz / 32'd2_000_000 + 32'd1;

    // Pulse counter width and its terminal value
    localparam int unsigned pulse_w = $clog2(en_pulse_cyc);
    localparam logic [pulse_w-1:0] pulse_last = pulse_w'(en_pulse_cyc - 1);

    localparam int unsigned delay_w = 20;

    localparam logic [delay_w-1:0] power_on_cyc   = delay_w'(clk_freq_hz / 32'd1_000 * 32'd15);
    localparam logic [delay_w-1:0] init1_wait_cyc = delay_w'(clk_freq_hz / 32'd10_000 * 32'd41);
    localparam logic [delay_w-1:0] init_wait_cyc  = delay_w'(clk_freq_hz / 32'd10_000);
    localparam logic [delay_w-1:0] cmd_wait_cyc   = delay_w'(clk_freq_hz / 32'd1_000_000 * 32'd40);
    localparam logic [delay_w-1:0] clear_wait_cyc =
        delay_w'(clk_freq_hz / 32'd1_000_000 * 32'd1_600);

    // ------------------------------------------------------------
    // Banner message
    // ------------------------------------------------------------
    typedef logic [3:0] msg_idx_t;

    localparam msg_idx_t msg_len = 4'd10;  // "THE GAME" plus two spaces

    // ------------------------------------------------------------
    // Byte request and LCD pins
    // ------------------------------------------------------------
    typedef struct packed {
        logic       is_data;  // RS level for this byte
        logic [7:0] value;
    } lcd_byte_t;

    typedef struct packed {
        logic       rs;
        logic       en;
        logic [3:0] data;     // D7..D4
    } lcd_bus_t;

    // Init commands in the order they go out
    typedef enum logic [3:0] {
        func_8bit_a,
        func_8bit_b,
        func_8bit_c,
        func_4bit,
        func_set,
        disp_off,
        clear,
        entry,
        disp_on
    } init_step_e;

    typedef enum logic [2:0] {
        power_wait,
        send,
        release_req,
        post_delay,
        done
    } seq_state_e;

    typedef enum logic [2:0] {
        idle,
        setup_hi,
        en_hi,
        hold_hi,
        setup_lo,
        en_lo,
        hold_lo,
        ack_wait
    } nib_state_e;

endpackage

`default_nettype wire

// ==== design/lcd_nibble_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_nibble_writer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 byte_req,
    input  lcd_pkg::lcd_byte_t   byte_data,
    output logic                 byte_ack,
    output lcd_pkg::lcd_bus_t    lcd
);

    lcd_pkg::nib_state_e          state;
    logic [lcd_pkg::pulse_w-1:0]  pulse_cnt;
    lcd_pkg::lcd_byte_t           lat_byte;
    logic                         accept;
    logic                         pulse_end;

    assign accept    = (state == lcd_pkg::idle) && byte_req;
    assign pulse_end = (pulse_cnt == lcd_pkg::pulse_last);

    // Holds the low nibble until its turn on the bus
    always_ff @(posedge clk) begin
        if (accept) begin
            lat_byte <= byte_data;
        end
    end

    // ------------------------------------------------------------
    // Nibble FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= lcd_pkg::idle;
            pulse_cnt <= '0;
            byte_ack  <= 1'b0;
            lcd       <= '0;
        end else begin
            case (state)
                lcd_pkg::idle: begin
                    lcd <= '0;  // Bus rests low between bytes and after the banner
                    if (accept) begin
                        lcd.rs   <= byte_data.is_data;
                        lcd.data <= byte_data.value[7:4];
                        state    <= lcd_pkg::setup_hi;
                    end
                end
                lcd_pkg::setup_hi: begin
                    lcd.en    <= 1'b1;
                    pulse_cnt <= '0;
                    state     <= lcd_pkg::en_hi;
                end
                lcd_pkg::en_hi: begin
                    pulse_cnt <= pulse_cnt + 1'b1;
                    if (pulse_end) begin
                        lcd.en    <= 1'b0;  // LCD latches the high nibble here
                        pulse_cnt <= '0;
                        state     <= lcd_pkg::hold_hi;
                    end
                end
                lcd_pkg::hold_hi: begin
                    pulse_cnt <= pulse_cnt + 1'b1;
                    if (pulse_end) begin
                        lcd.rs    <= lat_byte.is_data;
                        lcd.data  <= lat_byte.value[3:0];
                        pulse_cnt <= '0;
                        state     <= lcd_pkg::setup_lo;
                    end
                end
                lcd_pkg::setup_lo: begin
                    lcd.en    <= 1'b1;
                    pulse_cnt <= '0;
                    state     <= lcd_pkg::en_lo;
                end
                lcd_pkg::en_lo: begin
                    pulse_cnt <= pulse_cnt + 1'b1;
                    if (pulse_end) begin
                        lcd.en    <= 1'b0;
                        pulse_cnt <= '0;
                        state     <= lcd_pkg::hold_lo;
                    end
                end
                lcd_pkg::hold_lo: begin
                    pulse_cnt <= pulse_cnt + 1'b1;
                    if (pulse_end) begin
                        pulse_cnt <= '0;
                        byte_ack  <= 1'b1;
                        state     <= lcd_pkg::ack_wait;
                    end
                end
                lcd_pkg::ack_wait: begin
                    // Ack drops once req is gone
                    if (!byte_req) begin
                        byte_ack <= 1'b0;
                        lcd      <= '0;
                        state    <= lcd_pkg::idle;
                    end
                end
                default: state <= lcd_pkg::idle;
            endcase
        end
    end

    // ------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------
    a_bus_stable_en: assert property (@(posedge clk) disable iff (!rst_n)
        lcd.en && $past(lcd.en) |-> $stable(lcd.rs) && $stable(lcd.data));

    a_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(byte_ack) |-> byte_req);

endmodule

`default_nettype wire

// ==== design/lcd_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    output logic                 byte_req,
    output lcd_pkg::lcd_byte_t   byte_data,
    input  logic                 byte_ack
);

    lcd_pkg::seq_state_e           state;
    lcd_pkg::init_step_e           step;
    lcd_pkg::msg_idx_t             msg_idx;
    logic                          msg_phase;  // Set once the init list is through
    logic [lcd_pkg::delay_w-1:0]   delay_cnt;
    lcd_pkg::lcd_byte_t            cur_byte;
    logic [lcd_pkg::delay_w-1:0]   cur_delay;

    // ------------------------------------------------------------
    // Step tables
    // ------------------------------------------------------------
    function automatic logic [7:0] cmd_value(input lcd_pkg::init_step_e s);
        case (s)
            lcd_pkg::func_8bit_a: return 8'h30;
            lcd_pkg::func_8bit_b: return 8'h30;
            lcd_pkg::func_8bit_c: return 8'h30;
            lcd_pkg::func_4bit:   return 8'h20;  // Switch to 4-bit bus
            lcd_pkg::func_set:    return 8'h28;  // Two lines and 5x8 font
            lcd_pkg::disp_off:    return 8'h08;
            lcd_pkg::clear:       return 8'h01;
            lcd_pkg::entry:       return 8'h06;  // Increment without shift
            lcd_pkg::disp_on:     return 8'h0C;  // Cursor and blink off
            default:              return 8'h00;
        endcase
    endfunction

    function automatic logic [lcd_pkg::delay_w-1:0] cmd_delay(input lcd_pkg::init_step_e s);
        case (s)
            lcd_pkg::func_8bit_a: return lcd_pkg::init1_wait_cyc;
            lcd_pkg::func_8bit_b,
            lcd_pkg::func_8bit_c,
            lcd_pkg::func_4bit:   return lcd_pkg::init_wait_cyc;
            lcd_pkg::clear:       return lcd_pkg::clear_wait_cyc;
            default:              return lcd_pkg::cmd_wait_cyc;
        endcase
    endfunction

    function automatic logic [7:0] msg_char(input lcd_pkg::msg_idx_t idx);
        case (idx)
            4'd0:    return "T";
            4'd1:    return "H";
            4'd2:    return "E";
            4'd4:    return "G";
            4'd5:    return "A";
            4'd6:    return "M";
            4'd7:    return "E";
            default: return " ";  // Positions 3, 8 and 9
        endcase
    endfunction

    always_comb begin
        if (msg_phase) begin
            cur_byte  = '{is_data: 1'b1, value: msg_char(msg_idx)};
            cur_delay = lcd_pkg::cmd_wait_cyc;
        end else begin
            cur_byte  = '{is_data: 1'b0, value: cmd_value(step)};
            cur_delay = cmd_delay(step);
        end
    end

    // Payload follows the step while a request is being made
    always_ff @(posedge clk) begin
        if (state == lcd_pkg::send) begin
            byte_data <= cur_byte;
        end
    end

    // ------------------------------------------------------------
    // Sequencer FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= lcd_pkg::power_wait;
            step      <= lcd_pkg::func_8bit_a;
            msg_idx   <= '0;
            msg_phase <= 1'b0;
            delay_cnt <= lcd_pkg::power_on_cyc - 1'b1;
            byte_req  <= 1'b0;
        end else begin
            case (state)
                lcd_pkg::power_wait: begin
                    if (delay_cnt == '0) begin
                        state <= lcd_pkg::send;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                lcd_pkg::send: begin
                    byte_req <= 1'b1;
                    if (byte_ack) begin
                        byte_req <= 1'b0;
                        state    <= lcd_pkg::release_req;
                    end
                end
                lcd_pkg::release_req: begin
                    if (!byte_ack) begin
                        delay_cnt <= cur_delay - 1'b1;
                        state     <= lcd_pkg::post_delay;
                    end
                end
                lcd_pkg::post_delay: begin
                    if (delay_cnt != '0) begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end else if (msg_phase) begin
                        if (msg_idx == lcd_pkg::msg_len - 1'b1) begin
                            state <= lcd_pkg::done;
                        end else begin
                            msg_idx <= msg_idx + 1'b1;
                            state   <= lcd_pkg::send;
                        end
                    end else begin
                        if (step == lcd_pkg::disp_on) begin
                            msg_phase <= 1'b1;  // Banner text follows the init list
                            msg_idx   <= '0;
                        end else begin
                            step <= lcd_pkg::init_step_e'(step + 4'd1);
                        end
                        state <= lcd_pkg::send;
                    end
                end
                lcd_pkg::done: byte_req <= 1'b0;
                default:       state    <= lcd_pkg::done;
            endcase
        end
    end

    a_byte_stable: assert property (@(posedge clk) disable iff (!rst_n)
        byte_req && $past(byte_req) |-> $stable(byte_data));

    // Request only drops once the writer has acked
    a_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(byte_req) |-> byte_ack);

endmodule

`default_nettype wire

// ==== design/lcd_banner_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_banner_top (
    input  logic                 clk,
    input  logic                 rst_n,
    output lcd_pkg::lcd_bus_t    lcd
);

    // Sequencer to writer handshake
    logic                  byte_req;
    logic                  byte_ack;
    lcd_pkg::lcd_byte_t    byte_data;

    lcd_sequencer seq_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .byte_req  (byte_req),
        .byte_data (byte_data),
        .byte_ack  (byte_ack)
    );

    lcd_nibble_writer writer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .byte_req  (byte_req),
        .byte_data (byte_data),
        .byte_ack  (byte_ack),
        .lcd       (lcd)
    );

endmodule

`default_nettype wire

// ==== dv/lcd_bus_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_bus_monitor (
    input  logic                 clk,
    input  logic                 rst_n,
    input  lcd_pkg::lcd_bus_t    lcd,
    input  lcd_pkg::lcd_byte_t   exp_byte,   // Reference for the byte being decoded
    input  int                   exp_gap,    // Post-delay of the previous byte
    output int                   byte_cnt,
    output int                   pass_cnt,
    output int                   fail_cnt,
    output logic                 finished
);

    int                 cyc;
    int                 rel_cyc;     // Last cycle with reset asserted
    int                 rise_cyc;
    int                 fall_cyc;    // Final en fall of the latest byte
    lcd_pkg::lcd_bus_t  prev;
    logic               low_ok;
    logic               first_seen;
    logic               has_hi;
    logic               stable_ok;
    logic               width_ok;
    logic               idle_ok;
    logic [3:0]         hi_nib;
    logic               hi_rs;

    task automatic report_check(input logic ok, input string msg);
        if (ok) begin
            pass_cnt = pass_cnt + 1;
            $display("ok      %s", msg);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("FAILED  t=%0t  %s", $time, msg);
        end
    endtask

    initial begin
        cyc        = 0;
        rel_cyc    = 0;
        rise_cyc   = 0;
        fall_cyc   = 0;
        byte_cnt   = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        prev       = '0;
        low_ok     = 1'b1;
        stable_ok  = 1'b1;
        width_ok   = 1'b1;
        idle_ok    = 1'b1;
        first_seen = 1'b0;
        has_hi     = 1'b0;
        finished   = 1'b0;
        hi_nib     = '0;
        hi_rs      = 1'b0;
    end

    // ------------------------------------------------------------
    // Bus sampling mid-cycle where the DUT outputs are settled
    // ------------------------------------------------------------
    always @(negedge clk) begin : sample
        logic [7:0] got;
        int         min_gap;
        int         gap;
        got     = '0;
        min_gap = 0;
        gap     = 0;
        cyc     = cyc + 1;
        if (!rst_n) begin
            rel_cyc = cyc;
            if (lcd != '0) low_ok = 1'b0;
        end else begin
            if (!first_seen && (cyc - rel_cyc) < int'(lcd_pkg::power_on_cyc) && lcd != '0)
                low_ok = 1'b0;
            if (lcd.en && !prev.en) begin
                rise_cyc = cyc;
                if (!first_seen) begin
                    first_seen = 1'b1;
                    report_check(low_ok && (cyc - rel_cyc) >= int'(lcd_pkg::power_on_cyc),
                        $sformatf("first enable %0d cycles after reset, bus low before it",
                                  cyc - rel_cyc));
                end else if (!has_hi && byte_cnt > 0 && byte_cnt < 19) begin
                    gap     = cyc - fall_cyc;
                    min_gap = exp_gap + int'(lcd_pkg::en_pulse_cyc);
                    report_check(gap >= min_gap && gap <= min_gap + 8,
                        $sformatf("gap before byte %0d is %0d cycles, window %0d..%0d",
                                  byte_cnt, gap, min_gap, min_gap + 8));
                end
            end
            if (lcd.en && prev.en && (lcd.rs != prev.rs || lcd.data != prev.data))
                stable_ok = 1'b0;
            if (!lcd.en && prev.en) begin
                if (cyc - rise_cyc < int'(lcd_pkg::en_pulse_cyc)) width_ok = 1'b0;
                if (!has_hi) begin
                    hi_nib = prev.data;  // High nibble comes first
                    hi_rs  = prev.rs;
                    has_hi = 1'b1;
                end else begin
                    got      = {hi_nib, prev.data};
                    has_hi   = 1'b0;
                    fall_cyc = cyc;
                    if (byte_cnt >= 19) begin
                        report_check(1'b0, $sformatf("extra byte %02h after the message", got));
                    end else begin
                        report_check(got == exp_byte.value && hi_rs == exp_byte.is_data &&
                                     prev.rs == exp_byte.is_data && stable_ok && width_ok,
                            $sformatf("byte %0d got rs=%0b %02h, expected rs=%0b %02h, %s%s",
                                      byte_cnt, prev.rs, got, exp_byte.is_data,
                                      exp_byte.value, width_ok ? "" : "short enable ",
                                      stable_ok ? "bus stable" : "bus changed under enable"));
                    end
                    byte_cnt  = byte_cnt + 1;
                    stable_ok = 1'b1;
                    width_ok  = 1'b1;
                end
            end
            // Quiet bus once the banner is out
            if (byte_cnt >= 19 && !finished) begin
                if (cyc - fall_cyc > int'(lcd_pkg::cmd_wait_cyc) && lcd != '0) idle_ok = 1'b0;
                if (cyc - fall_cyc == int'(lcd_pkg::cmd_wait_cyc) + 10_000) begin
                    report_check(idle_ok && byte_cnt == 19,
                        $sformatf("%0d bytes decoded, bus idle and low afterwards", byte_cnt));
                    finished <= 1'b1;
                end
            end
        end
        prev = lcd;
    end

endmodule

`default_nettype wire

// ==== dv/lcd_banner_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lcd_banner_tb;

    logic                clk;
    logic                rst_n;
    lcd_pkg::lcd_bus_t   lcd;
    lcd_pkg::lcd_byte_t  exp_byte;
    int                  exp_gap;
    int                  byte_cnt;
    int                  pass_cnt;
    int                  fail_cnt;
    logic                finished;
    logic                timed_out;
    int                  waited;
    int                  run_limit;

    // ------------------------------------------------------------
    // Reference model of the byte stream
    // ------------------------------------------------------------
    function automatic lcd_pkg::lcd_byte_t expected_byte(input int pos);
        logic [79:0]        banner;
        lcd_pkg::lcd_byte_t b;
        banner    = "THE GAME  ";
        b.is_data = (pos >= 9);
        if (pos >= 9 && pos <= 18) begin
            b.value = banner[8*(18 - pos) +: 8];
        end else begin
            case (pos)
                0, 1, 2: b.value = 8'h30;  // 8-bit function set sent three times
                3:       b.value = 8'h20;
                4:       b.value = 8'h28;
                5:       b.value = 8'h08;
                6:       b.value = 8'h01;
                7:       b.value = 8'h06;
                8:       b.value = 8'h0C;
                default: b.value = 8'h00;
            endcase
        end
        return b;
    endfunction

    function automatic int post_delay(input int pos);
        case (pos)
            0:       return int'(lcd_pkg::init1_wait_cyc);
            1, 2, 3: return int'(lcd_pkg::init_wait_cyc);
            6:       return int'(lcd_pkg::clear_wait_cyc);  // Clear display is slow
            default: return int'(lcd_pkg::cmd_wait_cyc);
        endcase
    endfunction

    assign exp_byte = expected_byte(byte_cnt);
    assign exp_gap  = post_delay(byte_cnt - 1);

    lcd_banner_top dut_i (
        .clk   (clk),
        .rst_n (rst_n),
        .lcd   (lcd)
    );

    lcd_bus_monitor mon_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .lcd      (lcd),
        .exp_byte (exp_byte),
        .exp_gap  (exp_gap),
        .byte_cnt (byte_cnt),
        .pass_cnt (pass_cnt),
        .fail_cnt (fail_cnt),
        .finished (finished)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin : run
        rst_n     = 1'b0;
        timed_out = 1'b0;
        waited    = 0;
        run_limit = 1_200_000;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n <= 1'b1;
        // First enable pulse
        while (!lcd.en && waited < int'(lcd_pkg::power_on_cyc) + 1_000) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!lcd.en) begin
            timed_out = 1'b1;
            $display("Timeout: no enable pulse seen after the power-on wait");
        end
        // The rest of the run shares the overall cycle budget
        while (!timed_out && !finished && waited < run_limit) begin
            @(negedge clk);
            waited = waited + 1;
        end
        if (!timed_out && !finished) begin
            timed_out = 1'b1;
            $display("Timeout: banner and idle check not complete in %0d cycles", run_limit);
        end
        $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && !timed_out) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
design/lcd_pkg.sv
design/lcd_nibble_writer.sv
design/lcd_sequencer.sv
design/lcd_banner_top.sv
dv/lcd_bus_monitor.sv
dv/lcd_banner_tb.sv

// ==== Bender.yml ====
package:
  name: lcd_banner

sources:
  - design/lcd_pkg.sv
  - design/lcd_nibble_writer.sv
  - design/lcd_sequencer.sv
  - design/lcd_banner_top.sv
  - target: test
    files:
      - dv/lcd_bus_monitor.sv
      - dv/lcd_banner_tb.sv
